//--- rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	// cache geometry
	localparam int WORD_BITS      = 32;
	localparam int WORD_ADDR_BITS = 30;
	localparam int WORDS_PER_LINE = 4;
	localparam int OFFSET_BITS    = 2;
	localparam int SETS           = 64;
	localparam int INDEX_BITS     = 6;
	localparam int WAYS           = 2;
	localparam int TAG_BITS       = 22;  // word address above index and offset
	localparam int LINE_BITS      = 128;
	localparam int LINE_ADDR_BITS = 28;

	// zero wstrb means read
	typedef struct packed {
		logic [WORD_ADDR_BITS-1:0] addr;
		logic [WORD_BITS-1:0]      wdata;
		logic [3:0]                wstrb;
	} cpu_req_t;

	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_op_e;

	typedef struct packed {
		logic [LINE_ADDR_BITS-1:0] addr;
		mem_op_e                   op;
		logic [LINE_BITS-1:0]      data;  // write-back line only
	} mem_req_t;

	typedef struct packed {
		logic                valid;
		logic                dirty;
		logic [TAG_BITS-1:0] tag;
	} tag_entry_t;

	typedef enum logic [1:0] {
		LOOKUP      = 2'd0,
		WRITEBACK   = 2'd1,
		REFILL_REQ  = 2'd2,
		REFILL_WAIT = 2'd3
	} ctrl_state_e;

endpackage

`default_nettype wire

//--- rtl/dcache_tag_array.sv
`default_nettype none

module dcache_tag_array import dcache_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [INDEX_BITS-1:0] index,
	input  logic [TAG_BITS-1:0]   tag,
	input  logic                  tag_write,
	input  logic                  tag_way,
	input  tag_entry_t            tag_entry,
	output logic                  hit,
	output logic                  hit_way,
	output logic                  victim_way,
	output logic                  victim_dirty,
	output logic [TAG_BITS-1:0]   victim_tag
);

	tag_entry_t entries [WAYS][SETS];
	tag_entry_t cur [WAYS];      // entries of the addressed set
	logic [WAYS-1:0] way_hit;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int w = 0; w < WAYS; w++) begin
				for (int s = 0; s < SETS; s++) begin
					entries[w][s] <= '0;
				end
			end
		end else if (tag_write) begin
			entries[tag_way][index] <= tag_entry;
		end
	end

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			cur[w] = entries[w][index];
			way_hit[w] = cur[w].valid && (cur[w].tag == tag);
		end
	end

	assign hit     = |way_hit;
	assign hit_way = way_hit[1];

	// invalid way 0 first, then invalid way 1, else way 0
	assign victim_way   = cur[0].valid && !cur[1].valid;
	assign victim_dirty = cur[victim_way].valid && cur[victim_way].dirty;
	assign victim_tag   = cur[victim_way].tag;

endmodule

`default_nettype wire

//--- rtl/dcache_data_array.sv
`default_nettype none

module dcache_data_array import dcache_pkg::*; (
	input  logic                   clk,
	input  logic [INDEX_BITS-1:0]  index,
	input  logic [OFFSET_BITS-1:0] offset,
	input  logic                   rd_en,
	input  logic                   rd_way,
	input  logic                   word_we,
	input  logic [3:0]             wstrb,
	input  logic [WORD_BITS-1:0]   wdata,
	input  logic                   line_we,
	input  logic                   wr_way,
	input  logic [LINE_BITS-1:0]   line_data,
	output logic [WORD_BITS-1:0]   rd_word,
	output logic [LINE_BITS-1:0]   victim_line
);

	logic [LINE_BITS-1:0] lines [WAYS][SETS];

	// line fill wins over a word write
	always_ff @(posedge clk) begin
		if (line_we) begin
			lines[wr_way][index] <= line_data;
		end else if (word_we) begin
			for (int b = 0; b < WORD_BITS / 8; b++) begin
				if (wstrb[b]) begin
					lines[wr_way][index][offset * WORD_BITS + b * 8 +: 8] <= wdata[b * 8 +: 8];
				end
			end
		end
	end

	// outputs hold while rd_en is low, the write-back reads victim_line from here
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_word     <= lines[rd_way][index][offset * WORD_BITS +: WORD_BITS];
			victim_line <= lines[0][index];  // only way 0 is ever written back
		end
	end

endmodule

`default_nettype wire

//--- rtl/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       req_valid,
	input  logic [3:0] wstrb,
	input  logic       hit,
	input  logic       hit_way,
	input  logic       victim_way,
	input  logic       victim_dirty,
	input  logic       mem_req_ready,
	input  logic       mem_resp_valid,
	output logic       req_ready,
	output logic       resp_valid,
	output logic       rd_en,
	output logic       rd_way,
	output logic       word_we,
	output logic       line_we,
	output logic       wr_way,
	output logic       tag_write,
	output logic       tag_way,
	output logic       dirty_set,
	output logic       mem_req_valid,
	output mem_op_e    mem_op,
	output logic       use_victim_addr
);

	ctrl_state_e state;
	ctrl_state_e state_next;
	logic refill_way;
	logic accept;
	logic miss;

	assign miss      = (state == LOOKUP) && req_valid && !hit;
	assign req_ready = (state == LOOKUP) && !(req_valid && !hit);
	assign accept    = req_valid && req_ready;

	always_comb begin
		state_next = state;
		unique case (state)
			LOOKUP: begin
				if (miss) begin
					state_next = victim_dirty ? WRITEBACK : REFILL_REQ;
				end
			end
			WRITEBACK: begin
				if (mem_req_ready) begin
					state_next = REFILL_REQ;
				end
			end
			REFILL_REQ: begin
				if (mem_req_ready) begin
					state_next = REFILL_WAIT;
				end
			end
			REFILL_WAIT: begin
				if (mem_resp_valid) begin
					state_next = LOOKUP;  // held request hits next
				end
			end
			default: state_next = LOOKUP;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= LOOKUP;
			refill_way <= 1'b0;
			resp_valid <= 1'b0;
		end else begin
			state      <= state_next;
			resp_valid <= accept && (wstrb == 4'b0000);
			if (miss) begin
				refill_way <= victim_way;  // fixed for the whole miss
			end
		end
	end

	// array strobes
	assign rd_en   = (state == LOOKUP) && req_valid;  // also captures the victim line at a miss
	assign rd_way  = hit_way;
	assign word_we = accept && (wstrb != 4'b0000);
	assign line_we = (state == REFILL_WAIT) && mem_resp_valid;
	assign wr_way  = line_we ? refill_way : hit_way;

	// write hit marks dirty, refill installs clean
	assign tag_write = word_we || line_we;
	assign tag_way   = wr_way;
	assign dirty_set = word_we;

	assign mem_req_valid   = (state == WRITEBACK) || (state == REFILL_REQ);
	assign mem_op          = (state == WRITEBACK) ? MEM_WRITE : MEM_READ;
	assign use_victim_addr = (state == WRITEBACK);

endmodule

`default_nettype wire

//--- rtl/dcache.sv
`default_nettype none

module dcache import dcache_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 req_valid,
	input  cpu_req_t             req,
	output logic                 req_ready,
	output logic                 resp_valid,
	output logic [WORD_BITS-1:0] resp_data,
	output logic                 mem_req_valid,
	output mem_req_t             mem_req,
	input  logic                 mem_req_ready,
	input  logic                 mem_resp_valid,
	input  logic [LINE_BITS-1:0] mem_resp_data
);

	logic [TAG_BITS-1:0]    addr_tag;
	logic [INDEX_BITS-1:0]  index;
	logic [OFFSET_BITS-1:0] offset;
	logic hit, hit_way, victim_way, victim_dirty;
	logic [TAG_BITS-1:0] victim_tag;
	logic rd_en, rd_way, word_we, line_we, wr_way;
	logic tag_write, tag_way, dirty_set, use_victim_addr;
	mem_op_e mem_op;
	tag_entry_t tag_entry;
	logic [LINE_BITS-1:0] victim_line;

	assign {addr_tag, index, offset} = req.addr;

	// hit writes and refills both carry the request tag
	assign tag_entry = '{valid: 1'b1, dirty: dirty_set, tag: addr_tag};

	assign mem_req.addr = use_victim_addr ? {victim_tag, index} : {addr_tag, index};
	assign mem_req.op   = mem_op;
	assign mem_req.data = victim_line;

	dcache_tag_array u_tag_array (
		.clk, .reset, .index, .tag(addr_tag), .tag_write, .tag_way, .tag_entry,
		.hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
	);

	dcache_data_array u_data_array (
		.clk, .index, .offset, .rd_en, .rd_way, .word_we,
		.wstrb(req.wstrb), .wdata(req.wdata), .line_we, .wr_way,
		.line_data(mem_resp_data), .rd_word(resp_data), .victim_line
	);

	dcache_ctrl u_ctrl (
		.clk, .reset, .req_valid, .wstrb(req.wstrb), .hit, .hit_way,
		.victim_way, .victim_dirty, .mem_req_ready, .mem_resp_valid,
		.req_ready, .resp_valid, .rd_en, .rd_way, .word_we, .line_we, .wr_way,
		.tag_write, .tag_way, .dirty_set, .mem_req_valid, .mem_op, .use_victim_addr
	);

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`default_nettype none

module tb_clock (
	output logic clk
);
	timeunit 1ns;
	timeprecision 1ps;

	initial clk = 1'b0;

	always #2 clk = ~clk;  // 4 ns period

endmodule

`default_nettype wire

//--- dv/dcache_assertions.sv
`default_nettype none

module dcache_assertions import dcache_pkg::*; (
	input logic        clk,
	input logic        reset,
	input logic        req_valid,
	input cpu_req_t    req,
	input logic        req_ready,
	input logic        resp_valid,
	input logic        mem_req_valid,
	input mem_req_t    mem_req,
	input logic        mem_req_ready,
	input ctrl_state_e state
);
	timeunit 1ns;
	timeprecision 1ps;

	mem_req_held: assert property (@(posedge clk) disable iff (reset)
		mem_req_valid && !mem_req_ready |=> $stable(mem_req))
		else $error("mem_req changed while waiting for mem_req_ready");

	// reads answer one cycle later, writes never answer
	resp_after_read: assert property (@(posedge clk) disable iff (reset)
		resp_valid |-> $past(req_valid && req_ready && req.wstrb == 4'b0000))
		else $error("resp_valid without an accepted read one cycle before");

	// memory stays quiet in LOOKUP until a request misses
	mem_req_after_miss: assert property (@(posedge clk) disable iff (reset)
		$rose(mem_req_valid) |-> $past(state == LOOKUP && req_valid && !req_ready))
		else $error("memory request raised without a miss in LOOKUP");

endmodule

bind dcache dcache_assertions u_assertions (
	.clk, .reset, .req_valid, .req, .req_ready, .resp_valid,
	.mem_req_valid, .mem_req, .mem_req_ready, .state(u_ctrl.state)
);

`default_nettype wire

//--- dv/dcache_tb.sv
`default_nettype none

module dcache_tb import dcache_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] SEED = 32'h6763c042;
	localparam int N_RANDOM   = 1000;
	localparam int MEM_AW     = 10;
	localparam int MEM_WORDS  = 1 << MEM_AW;
	localparam int MAX_CYCLES = (N_RANDOM + 20) * 20;  // a miss stays well under 20 cycles

	logic clk;
	logic reset;
	logic req_valid;
	cpu_req_t req;
	logic req_ready;
	logic resp_valid;
	logic [WORD_BITS-1:0] resp_data;
	logic mem_req_valid;
	mem_req_t mem_req;
	logic mem_req_ready;
	logic mem_resp_valid;
	logic [LINE_BITS-1:0] mem_resp_data;

	logic [WORD_BITS-1:0] golden [MEM_WORDS];
	logic [WORD_BITS-1:0] mem_model [MEM_WORDS];
	logic [LINE_ADDR_BITS-1:0] way0_line [SETS];  // way 0 is the only write-back source
	logic way0_valid [SETS];
	logic way0_dirty [SETS];
	logic way1_valid [SETS];
	int mem_reads;
	int mem_writes;
	int cycles = 0;
	logic [31:0] stim_rng;
	logic [31:0] mem_rng;

	tb_clock u_clock (.clk);

	dcache u_dcache (
		.clk, .reset, .req_valid, .req, .req_ready, .resp_valid, .resp_data,
		.mem_req_valid, .mem_req, .mem_req_ready, .mem_resp_valid, .mem_resp_data
	);

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [WORD_BITS-1:0] fill_word(input logic [31:0] a);
		return a * 32'h9e3779b1 ^ 32'h0badcafe;
	endfunction

	function automatic logic [WORD_ADDR_BITS-1:0] word_addr(input int tag, input int idx,
			input int off);
		return {TAG_BITS'(tag), INDEX_BITS'(idx), OFFSET_BITS'(off)};
	endfunction

	// golden word, strobed bytes of wdata merged in
	function automatic logic [WORD_BITS-1:0] expected_word(input logic [WORD_ADDR_BITS-1:0] addr,
			input logic [WORD_BITS-1:0] wdata, input logic [3:0] wstrb);
		logic [WORD_BITS-1:0] w;
		w = golden[addr[MEM_AW-1:0]];
		for (int b = 0; b < 4; b++) begin
			if (wstrb[b]) begin
				w[b * 8 +: 8] = wdata[b * 8 +: 8];
			end
		end
		return w;
	endfunction

	function automatic logic [LINE_BITS-1:0] golden_line(input logic [LINE_ADDR_BITS-1:0] line);
		logic [LINE_BITS-1:0] l;
		for (int k = 0; k < WORDS_PER_LINE; k++) begin
			l[k * WORD_BITS +: WORD_BITS] = golden[{line[MEM_AW-OFFSET_BITS-1:0], OFFSET_BITS'(k)}];
		end
		return l;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_word(input logic [WORD_BITS-1:0] got, input logic [WORD_BITS-1:0] exp,
			input string what);
		if (got !== exp) begin
			fail_run($sformatf("CHECK FAILED at %0t: %s got %08h expected %08h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
		if (got.addr !== exp.addr || got.op !== exp.op
				|| (exp.op == MEM_WRITE && got.data !== exp.data)) begin
			fail_run($sformatf("CHECK FAILED at %0t: mem_req op %0b addr %h expected op %0b addr %h",
				$time, got.op, got.addr, exp.op, exp.addr));
		end
	endtask

	// holds the request until accepted, returns on the next falling edge
	task automatic issue(input logic [WORD_ADDR_BITS-1:0] addr, input logic [WORD_BITS-1:0] wdata,
			input logic [3:0] wstrb);
		req_valid = 1'b1;
		req = '{addr: addr, wdata: wdata, wstrb: wstrb};
		do begin
			@(posedge clk);
		end while (!req_ready);
		@(negedge clk);
	endtask

	task automatic idle(input int n);
		req_valid = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	initial begin : compare
		logic read_pending;
		logic [WORD_BITS-1:0] read_exp;
		logic [LINE_ADDR_BITS-1:0] line;
		logic [INDEX_BITS-1:0] idx;
		logic wb_seen;
		mem_req_t exp;
		read_pending = 1'b0;
		wb_seen = 1'b0;
		mem_reads = 0;
		mem_writes = 0;
		for (int a = 0; a < MEM_WORDS; a++) begin
			golden[a] = fill_word(a);
		end
		for (int s = 0; s < SETS; s++) begin
			way0_line[s] = '0;
			way0_valid[s] = 1'b0;
			way0_dirty[s] = 1'b0;
			way1_valid[s] = 1'b0;
		end
		forever begin
			@(posedge clk);
			if (!reset) begin
				if (resp_valid !== read_pending) begin
					fail_run("resp_valid did not follow an accepted read by exactly one cycle");
				end
				if (read_pending) check_word(resp_data, read_exp, "read data");
				read_pending = 1'b0;
				line = req.addr[WORD_ADDR_BITS-1:OFFSET_BITS];
				idx = line[INDEX_BITS-1:0];
				if (req_valid && req_ready) begin
					if (req.wstrb == 4'b0000) begin
						read_pending = 1'b1;
						read_exp = expected_word(req.addr, '0, 4'b0000);
					end else begin
						golden[req.addr[MEM_AW-1:0]] = expected_word(req.addr, req.wdata, req.wstrb);
						if (way0_valid[idx] && way0_line[idx] == line) way0_dirty[idx] = 1'b1;
					end
				end
				if (mem_req_valid && mem_req_ready) begin
					if (way0_valid[idx] && way1_valid[idx] && way0_dirty[idx] && !wb_seen) begin
						exp = '{addr: way0_line[idx], op: MEM_WRITE, data: golden_line(way0_line[idx])};
						check_mem_req(mem_req, exp);
						wb_seen = 1'b1;
						mem_writes++;
					end else begin
						exp = '{addr: line, op: MEM_READ, data: '0};
						check_mem_req(mem_req, exp);
						wb_seen = 1'b0;
						mem_reads++;
						if (!way0_valid[idx] || way1_valid[idx]) begin  // refill lands in way 0
							way0_line[idx] = line;
							way0_valid[idx] = 1'b1;
							way0_dirty[idx] = 1'b0;
						end else begin
							way1_valid[idx] = 1'b1;
						end
					end
				end
			end
		end
	end

	initial begin : memory_model
		logic [LINE_ADDR_BITS-1:0] line;
		logic [LINE_BITS-1:0] data;
		mem_req_ready = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_data = '0;
		mem_rng = lcg(SEED);
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem_model[a] = fill_word(a);
		end
		forever begin
			@(negedge clk);
			mem_resp_valid = 1'b0;
			mem_rng = lcg(mem_rng);
			mem_req_ready = mem_rng[20] | mem_rng[21];  // ready about 3 cycles in 4
			@(posedge clk);
			if (!reset && mem_req_valid && mem_req_ready) begin
				line = mem_req.addr;
				for (int k = 0; k < WORDS_PER_LINE; k++) begin
					if (mem_req.op == MEM_WRITE) begin
						mem_model[{line[MEM_AW-OFFSET_BITS-1:0], OFFSET_BITS'(k)}] =
							mem_req.data[k * WORD_BITS +: WORD_BITS];
					end else begin
						data[k * WORD_BITS +: WORD_BITS] =
							mem_model[{line[MEM_AW-OFFSET_BITS-1:0], OFFSET_BITS'(k)}];
					end
				end
				if (mem_req.op == MEM_READ) begin
					mem_rng = lcg(mem_rng);
					repeat (mem_rng[25:24]) @(posedge clk);  // 1 to 4 cycles in all
					@(negedge clk);
					mem_req_ready = 1'b0;
					mem_resp_valid = 1'b1;
					mem_resp_data = data;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			fail_run($sformatf("timeout, run still going after %0d cycles", MAX_CYCLES));
		end
	end

	initial begin : stimulus
		int n;
		logic [31:0] r;
		logic [WORD_ADDR_BITS-1:0] a;
		logic [3:0] strb;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		stim_rng = SEED;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		if (req_ready !== 1'b1) fail_run("req_ready is not high after reset");

		n = mem_reads;
		issue(word_addr(1, 3, 2), '0, 4'b0000);
		if (mem_reads != n + 1) fail_run("first read did not fetch its line from memory");

		n = mem_reads + mem_writes;
		issue(word_addr(1, 3, 0), '0, 4'b0000);  // back to back hits
		issue(word_addr(1, 3, 3), '0, 4'b0000);
		if (mem_reads + mem_writes != n) fail_run("read hit sent a request to memory");

		issue(word_addr(1, 3, 2), 32'hdeadbeef, 4'b0101);
		issue(word_addr(1, 3, 2), '0, 4'b0000);

		// three lines on one index, the first one dirty
		issue(word_addr(1, 9, 1), '0, 4'b0000);
		issue(word_addr(1, 9, 1), 32'hcafef00d, 4'b1111);
		issue(word_addr(2, 9, 0), '0, 4'b0000);
		n = mem_writes;
		issue(word_addr(3, 9, 2), '0, 4'b0000);
		if (mem_writes != n + 1) fail_run("dirty victim line was not written back");
		issue(word_addr(1, 9, 1), '0, 4'b0000);

		for (int i = 0; i < N_RANDOM; i++) begin
			stim_rng = lcg(stim_rng);
			r = stim_rng;
			a = {{(TAG_BITS-2){1'b0}}, r[17:16], {(INDEX_BITS-2){1'b0}}, r[19:18], r[21:20]};
			strb = r[22] ? ((r[27:24] == 4'b0000) ? 4'b1111 : r[27:24]) : 4'b0000;
			stim_rng = lcg(stim_rng);
			issue(a, stim_rng, strb);
			if (r[30:28] == 3'd0) idle(2);
		end
		idle(4);
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
rtl/dcache_pkg.sv
rtl/dcache_tag_array.sv
rtl/dcache_data_array.sv
rtl/dcache_ctrl.sv
rtl/dcache.sv
dv/tb_clock.sv
dv/dcache_assertions.sv
dv/dcache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
RTL_TOP   ?= dcache
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= rtl/dcache_pkg.sv rtl/dcache_tag_array.sv rtl/dcache_data_array.sv \
             rtl/dcache_ctrl.sv rtl/dcache.sv

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard rtl/*.sv dv/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
